// File: verilog.f
+incdir+source
source/udma_pkg.sv
source/udma_apb_bridge.sv
source/udma_cfg_router.sv
source/udma_ctrl_regs.sv
source/udma_periph_regs.sv
source/udma_subsystem.sv
tb/tb_udma_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the udma testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    -f verilog.f --top-module tb_udma_subsystem -o tb_udma_subsystem > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/tb_udma_subsystem > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failures found" "$SIM_LOG"; then
    exit 1
fi
exit 0

// File: tb/tb_udma_subsystem.sv
// udma subsystem testbench
`timescale 1ns/10ps
`default_nettype none

`include "udma_defines.svh"

module tb_udma_subsystem;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int N_STEPS      = 33;
    localparam int PREADY_WAIT  = 10;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_EVENT
    } op_e;

    // event rows keep slots 3..0 of exp_data in one nibble each
    typedef struct packed {
        op_e                             op;
        logic [`UDMA_APB_ADDR_WIDTH-1:0] addr;
        logic [`UDMA_DATA_WIDTH-1:0]     data;
        logic [`UDMA_DATA_WIDTH-1:0]     exp_data;
        logic                            exp_err;
    } step_t;

    logic                                       sys_clk = 1'b0;
    logic                                       reset;
    logic [`UDMA_APB_ADDR_WIDTH-1:0]            paddr;
    logic [`UDMA_DATA_WIDTH-1:0]                pwdata;
    logic                                       pwrite;
    logic                                       psel;
    logic                                       penable;
    logic [`UDMA_DATA_WIDTH-1:0]                prdata;
    logic                                       pready;
    logic                                       pslverr;
    logic                                       event_valid;
    logic [`UDMA_EVT_ID_WIDTH-1:0]              event_data;
    logic                                       event_ready;
    udma_pkg::udma_evt_t [`UDMA_N_EVT_SLOTS-1:0] events;

    step_t steps [N_STEPS];
    int    n_filled;
    int    errors;

    udma_subsystem uut (
        .sys_clk_i     (sys_clk),
        .reset_i       (reset),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .pwrite_i      (pwrite),
        .psel_i        (psel),
        .penable_i     (penable),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr),
        .event_valid_i (event_valid),
        .event_data_i  (event_data),
        .event_ready_o (event_ready),
        .events_o      (events)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // paddr from peripheral id and register index
    function automatic logic [`UDMA_APB_ADDR_WIDTH-1:0] apb_addr(input int per_id, input int idx);
        return {per_id[`UDMA_PER_ID_WIDTH-1:0], idx[`UDMA_REG_ADDR_WIDTH-1:0], 2'b00};
    endfunction

    task automatic add_step(input op_e op, input logic [`UDMA_APB_ADDR_WIDTH-1:0] addr,
                            input logic [`UDMA_DATA_WIDTH-1:0] data,
                            input logic [`UDMA_DATA_WIDTH-1:0] exp_data, input logic exp_err);
        steps[n_filled] = '{op, addr, data, exp_data, exp_err};
        n_filled++;
    endtask

    task automatic check_data(input string name, input logic [`UDMA_DATA_WIDTH-1:0] exp,
                              input logic [`UDMA_DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_evt(input string name, input udma_pkg::udma_evt_t exp,
                             input udma_pkg::udma_evt_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic apply_access(input step_t s, input int idx);
        int waited;
        waited = 0;
        @(posedge sys_clk);
        paddr  <= s.addr;
        pwdata <= s.data;
        pwrite <= (s.op == OP_WRITE);
        psel   <= 1'b1;
        @(posedge sys_clk);
        penable <= 1'b1;
        // pready looked at mid-cycle
        @(negedge sys_clk);
        while (!pready && waited < PREADY_WAIT) begin
            @(negedge sys_clk);
            waited++;
        end
        if (!pready) begin
            $display("step %0d: pready did not arrive within %0d cycles", idx, PREADY_WAIT);
            errors++;
        end else begin
            check_err("pslverr_o", s.exp_err, pslverr);
            if (s.op == OP_READ) begin
                check_data("prdata_o", s.exp_data, prdata);
            end
        end
        @(posedge sys_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apply_event(input step_t s);
        udma_pkg::udma_evt_t exp_slot;
        @(posedge sys_clk);
        event_valid <= 1'b1;
        event_data  <= s.data[`UDMA_EVT_ID_WIDTH-1:0];
        // accepted on the next edge and seen in the slots one edge later
        @(posedge sys_clk);
        event_valid <= 1'b0;
        @(posedge sys_clk);
        @(negedge sys_clk);
        for (int i = 0; i < `UDMA_N_EVT_SLOTS; i++) begin
            exp_slot = (i < `UDMA_N_PERIPHS) ?
                       s.exp_data[i*`UDMA_EVT_WIDTH +: `UDMA_EVT_WIDTH] : '0;
            check_evt($sformatf("events_o[%0d]", i), exp_slot, events[i]);
        end
    endtask

    task automatic build_table();
        // selectors 0x5a 0x3c 0x5a 0xc3 in bytes 0..3
        add_step(OP_WRITE, apb_addr(0, 0), 32'hc35a_3c5a, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(0, 0), 32'h0, 32'hc35a_3c5a, 1'b0);
        // masks of peripheral i at id i+1
        add_step(OP_WRITE, apb_addr(1, 0), 32'h0000_0006, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(1, 0), 32'h0, 32'h0000_0006, 1'b0);
        add_step(OP_WRITE, apb_addr(2, 0), 32'hffff_fff5, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(2, 0), 32'h0, 32'h0000_0005, 1'b0);
        add_step(OP_WRITE, apb_addr(3, 0), 32'h0000_0003, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(3, 0), 32'h0, 32'h0000_0003, 1'b0);
        add_step(OP_WRITE, apb_addr(4, 0), 32'h0000_000f, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(4, 0), 32'h0, 32'h0000_000f, 1'b0);
        // unknown register indexes
        add_step(OP_WRITE, apb_addr(0, 9), 32'hdead_beef, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(0, 9), 32'h0, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(3, 7), 32'h0, 32'h0, 1'b0);
        // unmapped ids answer with an error
        add_step(OP_WRITE, apb_addr(5, 0), 32'hffff_ffff, 32'h0, 1'b1);
        add_step(OP_READ,  apb_addr(5, 0), 32'h0, 32'h0, 1'b1);
        add_step(OP_READ,  apb_addr(31, 1), 32'h0, 32'h0, 1'b1);
        // id 5 folds onto bank 0 if the range decode is missing
        add_step(OP_READ,  apb_addr(1, 0), 32'h0, 32'h0000_0006, 1'b0);
        add_step(OP_READ,  apb_addr(0, 0), 32'h0, 32'hc35a_3c5a, 1'b0);
        // events with expected slots {p3, p2, p1, p0}
        add_step(OP_EVENT, '0, 32'h5a, 32'h5150, 1'b0);
        add_step(OP_EVENT, '0, 32'h3c, 32'h2200, 1'b0);
        add_step(OP_EVENT, '0, 32'h77, 32'h0000, 1'b0);
        add_step(OP_EVENT, '0, 32'hc3, 32'h8000, 1'b0);
        add_step(OP_EVENT, '0, 32'h5a, 32'h5150, 1'b0);
        // counters after four matching events
        add_step(OP_READ,  apb_addr(0, 1), 32'h0, 32'd4, 1'b0);
        add_step(OP_READ,  apb_addr(1, 1), 32'h0, 32'd0, 1'b0);
        add_step(OP_READ,  apb_addr(2, 1), 32'h0, 32'd4, 1'b0);
        add_step(OP_READ,  apb_addr(3, 1), 32'h0, 32'd3, 1'b0);
        add_step(OP_READ,  apb_addr(4, 1), 32'h0, 32'd6, 1'b0);
        add_step(OP_WRITE, apb_addr(0, 1), 32'h1234_5678, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(0, 1), 32'h0, 32'd0, 1'b0);
        add_step(OP_WRITE, apb_addr(4, 1), 32'h0, 32'h0, 1'b0);
        add_step(OP_READ,  apb_addr(4, 1), 32'h0, 32'd0, 1'b0);
        add_step(OP_READ,  apb_addr(2, 1), 32'h0, 32'd4, 1'b0);
    endtask

    initial begin
        errors      = 0;
        n_filled    = 0;
        reset       <= 1'b1;
        paddr       <= '0;
        pwdata      <= '0;
        pwrite      <= 1'b0;
        psel        <= 1'b0;
        penable     <= 1'b0;
        event_valid <= 1'b0;
        event_data  <= '0;
        build_table();
        if (n_filled != N_STEPS) begin
            $display("stimulus table has %0d rows instead of %0d", n_filled, N_STEPS);
            errors++;
        end
        repeat (RESET_CYCLES) @(posedge sys_clk);
        reset <= 1'b0;
        @(posedge sys_clk);
        @(negedge sys_clk);
        // state right after reset
        check_err("pready_o", 1'b0, pready);
        check_err("pslverr_o", 1'b0, pslverr);
        check_data("prdata_o", '0, prdata);
        check_err("event_ready_o", 1'b1, event_ready);
        for (int i = 0; i < `UDMA_N_EVT_SLOTS; i++) begin
            check_evt($sformatf("events_o[%0d]", i), '0, events[i]);
        end
        for (int i = 0; i < n_filled; i++) begin
            if (steps[i].op == OP_EVENT) begin
                apply_event(steps[i]);
            end else begin
                apply_access(steps[i], i);
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // run time bound from the table length
    initial begin
        #((N_STEPS * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the run did not finish in time, errors: %0d", errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/udma_subsystem.sv
// udma subsystem top level
`timescale 1ns/10ps
`default_nettype none

`include "udma_defines.svh"

module udma_subsystem (
    input  wire logic                                   sys_clk_i,
    input  wire logic                                   reset_i,
    input  wire logic [`UDMA_APB_ADDR_WIDTH-1:0]        paddr_i,
    input  wire logic [`UDMA_DATA_WIDTH-1:0]            pwdata_i,
    input  wire logic                                   pwrite_i,
    input  wire logic                                   psel_i,
    input  wire logic                                   penable_i,
    output logic      [`UDMA_DATA_WIDTH-1:0]            prdata_o,
    output logic                                        pready_o,
    output logic                                        pslverr_o,
    input  wire logic                                   event_valid_i,
    input  wire logic [`UDMA_EVT_ID_WIDTH-1:0]          event_data_i,
    output logic                                        event_ready_o,
    output udma_pkg::udma_evt_t [`UDMA_N_EVT_SLOTS-1:0] events_o
);

    udma_pkg::cfg_req_t                       s_bridge_req;
    udma_pkg::cfg_rsp_t                       s_bridge_rsp;
    udma_pkg::cfg_req_t                       s_ctrl_req;
    udma_pkg::cfg_rsp_t                       s_ctrl_rsp;
    udma_pkg::cfg_req_t [`UDMA_N_PERIPHS-1:0] s_per_req;
    udma_pkg::cfg_rsp_t [`UDMA_N_PERIPHS-1:0] s_per_rsp;
    udma_pkg::udma_trig_t                     s_trig;

    udma_apb_bridge i_apb_bridge (
        .sys_clk_i (sys_clk_i),
        .reset_i   (reset_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pwrite_i  (pwrite_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cfg_req_o (s_bridge_req),
        .cfg_rsp_i (s_bridge_rsp)
    );

    udma_cfg_router i_cfg_router (
        .sys_clk_i  (sys_clk_i),
        .reset_i    (reset_i),
        .req_i      (s_bridge_req),
        .rsp_o      (s_bridge_rsp),
        .ctrl_req_o (s_ctrl_req),
        .ctrl_rsp_i (s_ctrl_rsp),
        .per_req_o  (s_per_req),
        .per_rsp_i  (s_per_rsp)
    );

    udma_ctrl_regs i_ctrl_regs (
        .sys_clk_i     (sys_clk_i),
        .reset_i       (reset_i),
        .cfg_req_i     (s_ctrl_req),
        .cfg_rsp_o     (s_ctrl_rsp),
        .event_valid_i (event_valid_i),
        .event_data_i  (event_data_i),
        .event_ready_o (event_ready_o),
        .trig_o        (s_trig)
    );

    // peripheral 0 takes no triggers, like the uart
    for (genvar g = 0; g < `UDMA_N_PERIPHS; g++) begin : g_periph
        udma_periph_regs #(
            .accept_triggers ((g == 0) ? 0 : 1)
        ) i_periph_regs (
            .sys_clk_i (sys_clk_i),
            .reset_i   (reset_i),
            .cfg_req_i (s_per_req[g]),
            .cfg_rsp_o (s_per_rsp[g]),
            .trig_i    (s_trig),
            .evt_o     (events_o[g])
        );
    end

    // unused event slots
    for (genvar g = `UDMA_N_PERIPHS; g < `UDMA_N_EVT_SLOTS; g++) begin : g_evt_zero
        assign events_o[g] = '0;
    end

endmodule

`default_nettype wire

// File: source/udma_periph_regs.sv
// udma peripheral register bank
`timescale 1ns/10ps
`default_nettype none

`include "udma_defines.svh"

module udma_periph_regs #(
    parameter int accept_triggers = 1
) (
    input  wire logic           sys_clk_i,
    input  wire logic           reset_i,
    input  udma_pkg::cfg_req_t  cfg_req_i,
    output udma_pkg::cfg_rsp_t  cfg_rsp_o,
    input  udma_pkg::udma_trig_t trig_i,
    output udma_pkg::udma_evt_t evt_o
);

    localparam int POP_W = $clog2(`UDMA_N_TRIGGERS + 1);
    localparam int SUM_W = `UDMA_CNT_WIDTH + 1;

    udma_pkg::udma_trig_t        mask_q;
    udma_pkg::udma_trig_t        masked_trig;
    logic [`UDMA_CNT_WIDTH-1:0]  trig_cnt_q;
    logic [POP_W-1:0]            trig_pop;
    logic [SUM_W-1:0]            cnt_sum;
    logic [`UDMA_DATA_WIDTH-1:0] rdata;
    logic                        wr_en;

    assign wr_en = cfg_req_i.valid && !cfg_req_i.rwn;

    if (accept_triggers != 0) begin : g_trig
        assign masked_trig = trig_i & mask_q;
    end else begin : g_no_trig
        // no event input on this peripheral
        assign masked_trig = '0;
    end

    // number of triggers in this word
    always_comb begin
        trig_pop = '0;
        for (int k = 0; k < `UDMA_N_TRIGGERS; k++) begin
            trig_pop = trig_pop + POP_W'(masked_trig[k]);
        end
    end

    assign cnt_sum = {1'b0, trig_cnt_q} + SUM_W'(trig_pop);

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            mask_q     <= '0;
            trig_cnt_q <= '0;
            evt_o      <= '0;
        end else begin
            evt_o <= masked_trig;
            if (wr_en && cfg_req_i.reg_addr == udma_pkg::PER_TRIG_MASK) begin
                mask_q <= cfg_req_i.wdata[`UDMA_N_TRIGGERS-1:0];
            end
            if (wr_en && cfg_req_i.reg_addr == udma_pkg::PER_TRIG_CNT) begin
                trig_cnt_q <= '0;
            end else if (cnt_sum[SUM_W-1]) begin
                // saturate instead of wrapping
                trig_cnt_q <= '1;
            end else begin
                trig_cnt_q <= cnt_sum[`UDMA_CNT_WIDTH-1:0];
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (cfg_req_i.reg_addr)
            udma_pkg::PER_TRIG_MASK: rdata[`UDMA_N_TRIGGERS-1:0] = mask_q;
            udma_pkg::PER_TRIG_CNT:  rdata[`UDMA_CNT_WIDTH-1:0] = trig_cnt_q;
            default:                 rdata = '0;
        endcase
    end

    always_ff @(posedge sys_clk_i) begin
        cfg_rsp_o.rdata <= rdata;
        cfg_rsp_o.err   <= 1'b0;
        if (reset_i) begin
            cfg_rsp_o.ready <= 1'b0;
        end else begin
            cfg_rsp_o.ready <= cfg_req_i.valid;
        end
    end

endmodule

`default_nettype wire

// File: source/udma_ctrl_regs.sv
// udma control unit registers
`timescale 1ns/10ps
`default_nettype none

`include "udma_defines.svh"

module udma_ctrl_regs (
    input  wire logic                          sys_clk_i,
    input  wire logic                          reset_i,
    input  udma_pkg::cfg_req_t                 cfg_req_i,
    output udma_pkg::cfg_rsp_t                 cfg_rsp_o,
    input  wire logic                          event_valid_i,
    input  wire logic [`UDMA_EVT_ID_WIDTH-1:0] event_data_i,
    output logic                               event_ready_o,
    output udma_pkg::udma_trig_t               trig_o
);

    logic [`UDMA_DATA_WIDTH-1:0] evt_sel_q;
    logic [`UDMA_CNT_WIDTH-1:0]  match_cnt_q;
    logic [`UDMA_DATA_WIDTH-1:0] rdata;
    udma_pkg::udma_trig_t        hits;
    logic                        accept;
    logic                        wr_en;

    assign wr_en  = cfg_req_i.valid && !cfg_req_i.rwn;
    assign accept = event_valid_i && event_ready_o;

    // one selector per byte of evt_sel
    always_comb begin
        for (int k = 0; k < `UDMA_N_TRIGGERS; k++) begin
            hits[k] = (event_data_i == evt_sel_q[k*`UDMA_EVT_ID_WIDTH +: `UDMA_EVT_ID_WIDTH]);
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            event_ready_o <= 1'b0;
            trig_o        <= '0;
        end else begin
            event_ready_o <= 1'b1;
            trig_o        <= accept ? hits : '0;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            evt_sel_q   <= '0;
            match_cnt_q <= '0;
        end else begin
            if (wr_en && cfg_req_i.reg_addr == udma_pkg::CTRL_EVT_SEL) begin
                evt_sel_q <= cfg_req_i.wdata;
            end
            // any write clears the counter
            if (wr_en && cfg_req_i.reg_addr == udma_pkg::CTRL_MATCH_CNT) begin
                match_cnt_q <= '0;
            end else if (accept && |hits) begin
                match_cnt_q <= match_cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (cfg_req_i.reg_addr)
            udma_pkg::CTRL_EVT_SEL:   rdata = evt_sel_q;
            udma_pkg::CTRL_MATCH_CNT: rdata[`UDMA_CNT_WIDTH-1:0] = match_cnt_q;
            default:                  rdata = '0;
        endcase
    end

    // response one cycle after the request
    always_ff @(posedge sys_clk_i) begin
        cfg_rsp_o.rdata <= rdata;
        cfg_rsp_o.err   <= 1'b0;
        if (reset_i) begin
            cfg_rsp_o.ready <= 1'b0;
        end else begin
            cfg_rsp_o.ready <= cfg_req_i.valid;
        end
    end

endmodule

`default_nettype wire

// File: source/udma_cfg_router.sv
// udma configuration router
`timescale 1ns/10ps
`default_nettype none

`include "udma_defines.svh"

module udma_cfg_router (
    input  wire logic                                  sys_clk_i,
    input  wire logic                                  reset_i,
    input  udma_pkg::cfg_req_t                         req_i,
    output udma_pkg::cfg_rsp_t                         rsp_o,
    output udma_pkg::cfg_req_t                         ctrl_req_o,
    input  udma_pkg::cfg_rsp_t                         ctrl_rsp_i,
    output udma_pkg::cfg_req_t [`UDMA_N_PERIPHS-1:0]   per_req_o,
    input  udma_pkg::cfg_rsp_t [`UDMA_N_PERIPHS-1:0]   per_rsp_i
);

    localparam int IDX_W = (`UDMA_N_PERIPHS > 1) ? $clog2(`UDMA_N_PERIPHS) : 1;

    udma_pkg::cfg_req_t            req_q;
    logic [`UDMA_PER_ID_WIDTH-1:0] per_off;
    logic [IDX_W-1:0]              per_idx;
    logic                          sel_ctrl;
    logic                          sel_per;
    logic [IDX_W-1:0]              per_idx_q;
    logic                          sel_ctrl_q;
    logic                          err_q;

    always_ff @(posedge sys_clk_i) begin
        req_q <= req_i;
        if (reset_i) begin
            req_q.valid <= 1'b0;
        end
    end

    // single decode of the peripheral id
    assign per_off  = req_q.per_id - `UDMA_PER_ID_WIDTH'(`UDMA_PERIPH_ID_BASE);
    assign per_idx  = per_off[IDX_W-1:0];
    assign sel_ctrl = (req_q.per_id == `UDMA_PER_ID_WIDTH'(`UDMA_CTRL_ID));
    assign sel_per  = (req_q.per_id >= `UDMA_PER_ID_WIDTH'(`UDMA_PERIPH_ID_BASE)) &&
                      (per_off < `UDMA_PER_ID_WIDTH'(`UDMA_N_PERIPHS));

    always_comb begin
        ctrl_req_o       = req_q;
        ctrl_req_o.valid = req_q.valid && sel_ctrl;
        for (int i = 0; i < `UDMA_N_PERIPHS; i++) begin
            per_req_o[i]       = req_q;
            per_req_o[i].valid = req_q.valid && sel_per && (per_idx == IDX_W'(i));
        end
    end

    // remember the target for the returning response
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            sel_ctrl_q <= 1'b1;
            err_q      <= 1'b0;
        end else begin
            // unmapped id answers by itself one cycle later
            err_q <= req_q.valid && !sel_ctrl && !sel_per;
            if (req_q.valid) begin
                sel_ctrl_q <= sel_ctrl;
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (req_q.valid) begin
            per_idx_q <= per_idx;
        end
    end

    always_comb begin
        if (err_q) begin
            rsp_o.ready = 1'b1;
            rsp_o.err   = 1'b1;
            rsp_o.rdata = '0;
        end else if (sel_ctrl_q) begin
            rsp_o = ctrl_rsp_i;
        end else begin
            rsp_o = per_rsp_i[per_idx_q];
        end
    end

endmodule

`default_nettype wire

// File: source/udma_apb_bridge.sv
// udma apb bridge
`timescale 1ns/10ps
`default_nettype none

`include "udma_defines.svh"

module udma_apb_bridge (
    input  wire logic                            sys_clk_i,
    input  wire logic                            reset_i,
    input  wire logic [`UDMA_APB_ADDR_WIDTH-1:0] paddr_i,
    input  wire logic [`UDMA_DATA_WIDTH-1:0]     pwdata_i,
    input  wire logic                            pwrite_i,
    input  wire logic                            psel_i,
    input  wire logic                            penable_i,
    output logic      [`UDMA_DATA_WIDTH-1:0]     prdata_o,
    output logic                                 pready_o,
    output logic                                 pslverr_o,
    output udma_pkg::cfg_req_t                   cfg_req_o,
    input  udma_pkg::cfg_rsp_t                   cfg_rsp_i
);

    udma_pkg::apb_state_e state_q;

    // pready only in the done cycle
    assign pready_o = (state_q == udma_pkg::APB_DONE);

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            state_q         <= udma_pkg::APB_IDLE;
            cfg_req_o.valid <= 1'b0;
            prdata_o        <= '0;
            pslverr_o       <= 1'b0;
        end else begin
            cfg_req_o.valid <= 1'b0;
            case (state_q)
                udma_pkg::APB_IDLE: begin
                    // access phase starts one request
                    if (psel_i && penable_i) begin
                        cfg_req_o.valid <= 1'b1;
                        state_q         <= udma_pkg::APB_WAIT;
                    end
                end
                udma_pkg::APB_WAIT: begin
                    if (cfg_rsp_i.ready) begin
                        prdata_o  <= cfg_rsp_i.rdata;
                        pslverr_o <= cfg_rsp_i.err;
                        state_q   <= udma_pkg::APB_DONE;
                    end
                end
                default: begin
                    state_q <= udma_pkg::APB_IDLE;
                end
            endcase
        end
    end

    // request payload, split from the apb address
    always_ff @(posedge sys_clk_i) begin
        if (state_q == udma_pkg::APB_IDLE) begin
            cfg_req_o.rwn      <= ~pwrite_i;
            cfg_req_o.per_id   <= paddr_i[`UDMA_APB_ADDR_WIDTH-1 -: `UDMA_PER_ID_WIDTH];
            cfg_req_o.reg_addr <= paddr_i[2 +: `UDMA_REG_ADDR_WIDTH];
            cfg_req_o.wdata    <= pwdata_i;
        end
    end

endmodule

`default_nettype wire

// File: source/udma_pkg.sv
// udma shared types
`default_nettype none

`include "udma_defines.svh"

package udma_pkg;

    // one event slot and the trigger word
    typedef logic [`UDMA_EVT_WIDTH-1:0]  udma_evt_t;
    typedef logic [`UDMA_N_TRIGGERS-1:0] udma_trig_t;

    // configuration request, valid for one cycle
    typedef struct packed {
        logic                            valid;
        logic                            rwn;
        logic [`UDMA_PER_ID_WIDTH-1:0]   per_id;
        logic [`UDMA_REG_ADDR_WIDTH-1:0] reg_addr;
        logic [`UDMA_DATA_WIDTH-1:0]     wdata;
    } cfg_req_t;

    // configuration response, ready for one cycle
    typedef struct packed {
        logic                        ready;
        logic                        err;
        logic [`UDMA_DATA_WIDTH-1:0] rdata;
    } cfg_rsp_t;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_WAIT,
        APB_DONE
    } apb_state_e;

    // register indexes of the control unit
    typedef enum logic [`UDMA_REG_ADDR_WIDTH-1:0] {
        CTRL_EVT_SEL   = 0,
        CTRL_MATCH_CNT = 1
    } ctrl_reg_e;

    // register indexes of a peripheral bank
    typedef enum logic [`UDMA_REG_ADDR_WIDTH-1:0] {
        PER_TRIG_MASK = 0,
        PER_TRIG_CNT  = 1
    } periph_reg_e;

endpackage

`default_nettype wire

// File: source/udma_defines.svh
// udma width and address map constants
`ifndef UDMA_DEFINES_SVH
`define UDMA_DEFINES_SVH

// apb and register bus widths
`define UDMA_APB_ADDR_WIDTH 12
`define UDMA_DATA_WIDTH     32

// paddr[11:7] selects the peripheral, paddr[6:2] the register
`define UDMA_PER_ID_WIDTH   5
`define UDMA_REG_ADDR_WIDTH 5

// peripheral map
`define UDMA_N_PERIPHS      4
`define UDMA_CTRL_ID        0
`define UDMA_PERIPH_ID_BASE 1

// event side
`define UDMA_N_EVT_SLOTS    32
`define UDMA_EVT_WIDTH      4
`define UDMA_EVT_ID_WIDTH   8
`define UDMA_N_TRIGGERS     4

// match and trigger counters
`define UDMA_CNT_WIDTH      16

`endif
